// File: include/tinker_cfg.svh
`ifndef TINKER_CFG_SVH
`define TINKER_CFG_SVH

// ========================================
// widths and startup
// ========================================
`define TINKER_XLEN             64
`define TINKER_START_PC         64'h2000   // byte address of first instruction
`define TINKER_STARTUP_BUBBLES  3
`define TINKER_IMEM_WORDS       1024       // 32-bit words

// ========================================
// opcodes
// ========================================
`define TINKER_OP_AND     5'h00
`define TINKER_OP_OR      5'h01
`define TINKER_OP_XOR     5'h02
`define TINKER_OP_NOT     5'h03
`define TINKER_OP_SHFTR   5'h04
`define TINKER_OP_SHFTRI  5'h05
`define TINKER_OP_SHFTL   5'h06
`define TINKER_OP_SHFTLI  5'h07
`define TINKER_OP_BR      5'h08   // absolute, target in rd
`define TINKER_OP_BRR     5'h09   // pc + rd
`define TINKER_OP_BRRL    5'h0A   // pc + literal
`define TINKER_OP_BRNZ    5'h0B
`define TINKER_OP_BRGT    5'h0E
`define TINKER_OP_HALT    5'h0F
`define TINKER_OP_MOV     5'h11
`define TINKER_OP_MOVL    5'h12
`define TINKER_OP_STORE   5'h13
`define TINKER_OP_ADD     5'h18
`define TINKER_OP_ADDI    5'h19
`define TINKER_OP_SUB     5'h1A
`define TINKER_OP_SUBI    5'h1B

`endif

// File: src/tinker_pkg.sv
`include "tinker_cfg.svh"

package tinker_pkg;

    // ========================================
    // data and instruction words
    // ========================================
    typedef logic [`TINKER_XLEN-1:0] word_t;     // register / data value
    typedef logic [31:0]             inst_t;
    typedef logic [31:0]             daddr_t;    // store address

    // instruction fields
    typedef logic [4:0]              opcode_t;
    typedef logic [4:0]              reg_idx_t;
    typedef logic [11:0]             lit_t;      // sign extended on use

    // word index into instruction memory
    typedef logic [$clog2(`TINKER_IMEM_WORDS)-1:0] imem_idx_t;

    // ========================================
    // fetch control
    // ========================================
    typedef enum logic [1:0] {
        FETCH_IDLE,      // waiting for start
        FETCH_STARTUP,   // fixed bubbles before first fetch
        FETCH_RUN,
        FETCH_HALTED     // sticky until reset
    } fetch_state_t;

endpackage

// File: src/fetch_unit.sv
`timescale 1ns/100ps
`include "tinker_cfg.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  prog_we,
    input  tinker_pkg::imem_idx_t prog_addr,
    input  tinker_pkg::inst_t     prog_data,
    input  logic                  halt_seen,
    input  logic                  redirect,
    input  tinker_pkg::word_t     redirect_pc,
    output tinker_pkg::inst_t     f_inst,
    output tinker_pkg::word_t     f_pc
);
    localparam int CNT_W = $clog2(`TINKER_STARTUP_BUBBLES) + 1;

    tinker_pkg::inst_t        imem [`TINKER_IMEM_WORDS];
    tinker_pkg::word_t        pc;
    tinker_pkg::imem_idx_t    pc_idx;
    tinker_pkg::fetch_state_t state;
    logic [CNT_W-1:0]         startup_cnt;

    assign pc_idx = tinker_pkg::imem_idx_t'(pc >> 2); // start pc lands on word 0

    // program load port, usable before start
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // ========================================
    // pc, fetch FSM and fetch register
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= tinker_pkg::FETCH_IDLE;
            startup_cnt <= '0;
            pc          <= `TINKER_START_PC;
            f_inst      <= '0;
            f_pc        <= '0;
        end else begin
            f_inst <= '0;   // bubble unless a fetch happens below
            f_pc   <= '0;
            case (state)
                tinker_pkg::FETCH_IDLE: begin
                    if (start) begin
                        state       <= tinker_pkg::FETCH_STARTUP;
                        startup_cnt <= CNT_W'(`TINKER_STARTUP_BUBBLES - 1);
                    end
                end
                tinker_pkg::FETCH_STARTUP: begin
                    if (startup_cnt == '0) begin
                        state <= tinker_pkg::FETCH_RUN;
                    end else begin
                        startup_cnt <= startup_cnt - 1'b1;
                    end
                end
                tinker_pkg::FETCH_RUN: begin
                    if (redirect) begin
                        pc <= redirect_pc;   // squashed slot stays a bubble
                    end else if (halt_seen) begin
                        state <= tinker_pkg::FETCH_HALTED;
                    end else begin
                        f_inst <= imem[pc_idx];
                        f_pc   <= pc;
                        pc     <= pc + 64'd4;
                    end
                end
                default: begin
                    state <= tinker_pkg::FETCH_HALTED;   // held until reset
                end
            endcase
        end
    end

endmodule

// File: src/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::reg_idx_t rs,
    input  tinker_pkg::reg_idx_t rt,
    input  tinker_pkg::reg_idx_t rd,
    input  logic                 wb_en,
    input  tinker_pkg::reg_idx_t wb_rd,
    input  tinker_pkg::word_t    wb_data,
    output tinker_pkg::word_t    rs_val,
    output tinker_pkg::word_t    rt_val,
    output tinker_pkg::word_t    rd_val
);
    tinker_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through: a read of the register retiring this cycle gets the new value
    assign rs_val = (wb_en && wb_rd == rs) ? wb_data : regs[rs];
    assign rt_val = (wb_en && wb_rd == rt) ? wb_data : regs[rt];
    assign rd_val = (wb_en && wb_rd == rd) ? wb_data : regs[rd];   // store base, targets

endmodule

// File: src/decode_stage.sv
`timescale 1ns/100ps
`include "tinker_cfg.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::inst_t    f_inst,
    input  tinker_pkg::word_t    f_pc,
    input  logic                 redirect,
    input  logic                 wb_en,
    input  tinker_pkg::reg_idx_t wb_rd,
    input  tinker_pkg::word_t    wb_data,
    output logic                 halt_seen,
    output tinker_pkg::opcode_t  ex_op,
    output tinker_pkg::reg_idx_t ex_rd,
    output tinker_pkg::reg_idx_t ex_rs,
    output tinker_pkg::reg_idx_t ex_rt,
    output logic                 ex_lit_op,
    output tinker_pkg::word_t    ex_a,
    output tinker_pkg::word_t    ex_b,
    output tinker_pkg::word_t    ex_rdval,
    output tinker_pkg::word_t    ex_pc
);
    tinker_pkg::inst_t    inst;
    tinker_pkg::opcode_t  op;
    tinker_pkg::reg_idx_t rd;
    tinker_pkg::reg_idx_t rs;
    tinker_pkg::reg_idx_t rt;
    tinker_pkg::lit_t     lit;
    tinker_pkg::word_t    lit_ext;
    tinker_pkg::word_t    rs_val;
    tinker_pkg::word_t    rt_val;
    tinker_pkg::word_t    rd_val;
    logic                 lit_op;

    // ========================================
    // field split
    // ========================================
    // a killed slot decodes as the all-zero and r0, r0, r0
    assign inst    = (redirect || halt_seen) ? '0 : f_inst;
    assign op      = inst[31:27];
    assign rd      = inst[26:22];
    assign rs      = inst[21:17];
    assign rt      = inst[16:12];
    assign lit     = inst[11:0];
    assign lit_ext = {{(`TINKER_XLEN - 12){lit[11]}}, lit};

    always_comb begin
        case (op)
            `TINKER_OP_ADDI, `TINKER_OP_SUBI,
            `TINKER_OP_SHFTRI, `TINKER_OP_SHFTLI,
            `TINKER_OP_MOVL, `TINKER_OP_BRRL,
            `TINKER_OP_STORE: lit_op = 1'b1;
            default:          lit_op = 1'b0;
        endcase
    end

    register_file u_rf (
        .clk     (clk),
        .reset   (reset),
        .rs      (rs),
        .rt      (rt),
        .rd      (rd),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .rd_val  (rd_val)
    );

    // ========================================
    // decode-to-execute register
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            halt_seen <= 1'b0;
            ex_op     <= '0;
            ex_rd     <= '0;
            ex_rs     <= '0;
            ex_rt     <= '0;
            ex_lit_op <= 1'b0;
            ex_a      <= '0;
            ex_b      <= '0;
            ex_rdval  <= '0;
            ex_pc     <= '0;
        end else begin
            // a halt just behind a taken branch is squashed, so forget it
            if (redirect) begin
                halt_seen <= 1'b0;
            end else if (op == `TINKER_OP_HALT) begin
                halt_seen <= 1'b1;
            end
            ex_op     <= op;
            ex_rd     <= rd;
            ex_rs     <= rs;
            ex_rt     <= rt;
            ex_lit_op <= lit_op;
            ex_a      <= rs_val;
            ex_b      <= lit_op ? lit_ext : rt_val;
            ex_rdval  <= rd_val;
            ex_pc     <= f_pc;
        end
    end

endmodule

// File: src/execute_unit.sv
`timescale 1ns/100ps
`include "tinker_cfg.svh"

module execute_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::opcode_t  ex_op,
    input  tinker_pkg::reg_idx_t ex_rd,
    input  tinker_pkg::reg_idx_t ex_rs,
    input  tinker_pkg::reg_idx_t ex_rt,
    input  logic                 ex_lit_op,
    input  tinker_pkg::word_t    ex_a,
    input  tinker_pkg::word_t    ex_b,
    input  tinker_pkg::word_t    ex_rdval,
    input  tinker_pkg::word_t    ex_pc,
    output logic                 redirect,
    output tinker_pkg::word_t    redirect_pc,
    output logic                 wb_en,
    output tinker_pkg::reg_idx_t wb_rd,
    output tinker_pkg::word_t    wb_data,
    output logic                 st_valid,
    output tinker_pkg::daddr_t   st_addr,
    output tinker_pkg::word_t    st_data,
    output logic                 hlt
);
    // execute/memory register
    logic                 em_wen;
    logic                 em_halt;
    tinker_pkg::reg_idx_t em_rd;
    tinker_pkg::word_t    em_data;

    tinker_pkg::word_t    rs_fwd;
    tinker_pkg::word_t    rd_fwd;
    tinker_pkg::word_t    op1;
    tinker_pkg::word_t    op2;
    tinker_pkg::word_t    alu_res;
    tinker_pkg::word_t    alu_target;
    logic                 alu_wen;
    logic                 alu_st;
    logic                 alu_taken;
    logic                 alu_halt;

    // youngest in-flight writer wins
    function automatic tinker_pkg::word_t fwd(input tinker_pkg::reg_idx_t idx,
                                              input tinker_pkg::word_t    reg_val);
        if (em_wen && em_rd == idx) begin
            return em_data;
        end
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    // ========================================
    // operand forwarding
    // ========================================
    assign rs_fwd = fwd(ex_rs, ex_a);
    assign rd_fwd = fwd(ex_rd, ex_rdval);
    assign op2    = ex_lit_op ? ex_b : fwd(ex_rt, ex_b);
    assign op1    = (ex_op == `TINKER_OP_ADDI || ex_op == `TINKER_OP_SUBI) ? rd_fwd : rs_fwd;

    // ========================================
    // ALU and branch resolution
    // ========================================
    always_comb begin
        alu_res    = '0;
        alu_wen    = 1'b1;
        alu_st     = 1'b0;
        alu_taken  = 1'b0;
        alu_target = rd_fwd;   // most branches jump to rd
        alu_halt   = 1'b0;
        case (ex_op)
            `TINKER_OP_ADD, `TINKER_OP_ADDI:     alu_res = op1 + op2;
            `TINKER_OP_SUB, `TINKER_OP_SUBI:     alu_res = op1 - op2;
            `TINKER_OP_AND:                      alu_res = op1 & op2;
            `TINKER_OP_OR:                       alu_res = op1 | op2;
            `TINKER_OP_XOR:                      alu_res = op1 ^ op2;
            `TINKER_OP_NOT:                      alu_res = ~op1;
            `TINKER_OP_SHFTR, `TINKER_OP_SHFTRI: alu_res = op1 >> op2;
            `TINKER_OP_SHFTL, `TINKER_OP_SHFTLI: alu_res = op1 << op2;
            `TINKER_OP_MOV:                      alu_res = rs_fwd;
            `TINKER_OP_MOVL:                     alu_res = op2;
            `TINKER_OP_STORE: begin
                alu_wen = 1'b0;
                alu_st  = 1'b1;
            end
            `TINKER_OP_BR: begin
                alu_wen   = 1'b0;
                alu_taken = 1'b1;
            end
            `TINKER_OP_BRR: begin
                alu_wen    = 1'b0;
                alu_taken  = 1'b1;
                alu_target = ex_pc + rd_fwd;
            end
            `TINKER_OP_BRRL: begin
                alu_wen    = 1'b0;
                alu_taken  = 1'b1;
                alu_target = ex_pc + op2;
            end
            `TINKER_OP_BRNZ: begin
                alu_wen   = 1'b0;
                alu_taken = (rs_fwd != '0);
            end
            `TINKER_OP_BRGT: begin
                alu_wen   = 1'b0;
                alu_taken = ($signed(rs_fwd) > $signed(op2));
            end
            `TINKER_OP_HALT: begin
                alu_wen  = 1'b0;
                alu_halt = 1'b1;
            end
            default: alu_wen = 1'b0;
        endcase
    end

    // ========================================
    // execute/memory and memory/writeback
    // ========================================
    // entry behind a taken branch is dropped while redirect is high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            em_wen   <= 1'b0;
            em_halt  <= 1'b0;
            st_valid <= 1'b0;
            redirect <= 1'b0;
            wb_en    <= 1'b0;
            hlt      <= 1'b0;
        end else begin
            em_wen   <= alu_wen && !redirect;
            em_halt  <= alu_halt && !redirect;
            st_valid <= alu_st && !redirect;
            redirect <= alu_taken && !redirect;   // one cycle only
            wb_en    <= em_wen;
            if (em_halt) begin
                hlt <= 1'b1;   // sticky
            end
        end
    end

    always_ff @(posedge clk) begin
        em_rd       <= ex_rd;
        em_data     <= alu_res;
        redirect_pc <= alu_target;
        st_addr     <= tinker_pkg::daddr_t'(rd_fwd + op2);
        st_data     <= rs_fwd;
        wb_rd       <= em_rd;
        wb_data     <= em_data;
    end

endmodule

// File: src/tinker_core.sv
`timescale 1ns/100ps

module tinker_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  prog_we,
    input  tinker_pkg::imem_idx_t prog_addr,
    input  tinker_pkg::inst_t     prog_data,
    output logic                  st_valid,
    output tinker_pkg::daddr_t    st_addr,
    output tinker_pkg::word_t     st_data,
    output logic                  hlt
);
    // fetch to decode
    tinker_pkg::inst_t    f_inst;
    tinker_pkg::word_t    f_pc;
    logic                 halt_seen;

    // decode to execute
    tinker_pkg::opcode_t  ex_op;
    tinker_pkg::reg_idx_t ex_rd;
    tinker_pkg::reg_idx_t ex_rs;
    tinker_pkg::reg_idx_t ex_rt;
    logic                 ex_lit_op;
    tinker_pkg::word_t    ex_a;
    tinker_pkg::word_t    ex_b;
    tinker_pkg::word_t    ex_rdval;
    tinker_pkg::word_t    ex_pc;

    // execute back to fetch and decode
    logic                 redirect;
    tinker_pkg::word_t    redirect_pc;
    logic                 wb_en;
    tinker_pkg::reg_idx_t wb_rd;
    tinker_pkg::word_t    wb_data;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .halt_seen   (halt_seen),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .f_inst      (f_inst),
        .f_pc        (f_pc)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .f_inst    (f_inst),
        .f_pc      (f_pc),
        .redirect  (redirect),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .halt_seen (halt_seen),
        .ex_op     (ex_op),
        .ex_rd     (ex_rd),
        .ex_rs     (ex_rs),
        .ex_rt     (ex_rt),
        .ex_lit_op (ex_lit_op),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .ex_rdval  (ex_rdval),
        .ex_pc     (ex_pc)
    );

    execute_unit u_execute (
        .clk         (clk),
        .reset       (reset),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_rs       (ex_rs),
        .ex_rt       (ex_rt),
        .ex_lit_op   (ex_lit_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_rdval    (ex_rdval),
        .ex_pc       (ex_pc),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .st_valid    (st_valid),
        .st_addr     (st_addr),
        .st_data     (st_data),
        .hlt         (hlt)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;   // 10 ns period

endmodule

// File: verif/tinker_assertions.sv
`timescale 1ns/100ps
`include "tinker_cfg.svh"

module tinker_assertions #(
    parameter tinker_pkg::daddr_t POISON_ADDR = 32'hFFFF_FFF8
) (
    input logic                     clk,
    input logic                     reset,
    input logic                     start,
    input logic                     st_valid,
    input tinker_pkg::daddr_t       st_addr,
    input logic                     hlt,
    input tinker_pkg::fetch_state_t fetch_state
);
    // ========================================
    // before start
    // ========================================
    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        (fetch_state == tinker_pkg::FETCH_IDLE) |-> (!st_valid && !hlt))
        else begin
            tinker_tb.assert_fails++;
            $error("store or hlt seen before start");
        end

    // fixed idle cycles, then the first real fetch
    a_startup_bubbles: assert property (@(posedge clk) disable iff (reset)
        start |-> ##(`TINKER_STARTUP_BUBBLES) (fetch_state == tinker_pkg::FETCH_STARTUP)
        ##1 (fetch_state == tinker_pkg::FETCH_RUN))
        else begin
            tinker_tb.assert_fails++;
            $error("fetch did not run after the startup bubbles");
        end

    // skipped instructions must never store
    a_no_poison: assert property (@(posedge clk) disable iff (reset)
        st_valid |-> (st_addr != POISON_ADDR))
        else begin
            tinker_tb.assert_fails++;
            $error("store to poison address, squashed path executed");
        end

    // ========================================
    // halt
    // ========================================
    a_hlt_sticky: assert property (@(posedge clk) disable iff (reset)
        hlt |=> hlt)
        else begin
            tinker_tb.assert_fails++;
            $error("hlt dropped before reset");
        end

    a_no_store_after_hlt: assert property (@(posedge clk) disable iff (reset)
        hlt |-> !st_valid)
        else begin
            tinker_tb.assert_fails++;
            $error("store while hlt high");
        end

    a_fetch_halted: assert property (@(posedge clk) disable iff (reset)
        hlt |-> (fetch_state == tinker_pkg::FETCH_HALTED))
        else begin
            tinker_tb.assert_fails++;
            $error("hlt high while fetch not halted");
        end

endmodule

// File: verif/tinker_tb.sv
`timescale 1ns/100ps
`include "tinker_cfg.svh"

module tinker_tb;
    localparam int HLT_TIMEOUT = 2000;

    logic                  clk;
    logic                  reset;
    logic                  start;
    logic                  prog_we;
    tinker_pkg::imem_idx_t prog_addr;
    tinker_pkg::inst_t     prog_data;
    logic                  st_valid;
    tinker_pkg::daddr_t    st_addr;
    tinker_pkg::word_t     st_data;
    logic                  hlt;

    integer seed;
    int     err_count;
    int     assert_fails;
    int     rx_count;
    int     exp_total;
    int     slot;
    bit     aborted;
    string  test_name;

    tinker_pkg::inst_t  prog [$];
    tinker_pkg::word_t  m [32];        // architectural register model
    tinker_pkg::daddr_t exp_addr [$];
    tinker_pkg::word_t  exp_data [$];

    tb_clock u_clk (.clk(clk));

    tinker_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .st_valid  (st_valid),
        .st_addr   (st_addr),
        .st_data   (st_data),
        .hlt       (hlt)
    );

    // poison stores are r0 + (-8)
    bind tinker_core tinker_assertions #(.POISON_ADDR(32'hFFFF_FFF8)) u_assert (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .st_valid    (st_valid),
        .st_addr     (st_addr),
        .hlt         (hlt),
        .fetch_state (u_fetch.state)
    );

    // ========================================
    // instruction model
    // ========================================
    function automatic tinker_pkg::inst_t encode(tinker_pkg::opcode_t op,
        tinker_pkg::reg_idx_t rd, tinker_pkg::reg_idx_t rs,
        tinker_pkg::reg_idx_t rt, tinker_pkg::lit_t lit);
        return {op, rd, rs, rt, lit};
    endfunction

    function automatic tinker_pkg::word_t sext(tinker_pkg::lit_t lit);
        return {{52{lit[11]}}, lit};
    endfunction

    function automatic tinker_pkg::word_t model_result(tinker_pkg::opcode_t op,
        tinker_pkg::word_t v_rs, tinker_pkg::word_t v_rt,
        tinker_pkg::word_t v_rd, tinker_pkg::lit_t lit);
        case (op)
            `TINKER_OP_ADD:    return v_rs + v_rt;
            `TINKER_OP_ADDI:   return v_rd + sext(lit);   // accumulates into rd
            `TINKER_OP_SUB:    return v_rs - v_rt;
            `TINKER_OP_SUBI:   return v_rd - sext(lit);
            `TINKER_OP_AND:    return v_rs & v_rt;
            `TINKER_OP_OR:     return v_rs | v_rt;
            `TINKER_OP_XOR:    return v_rs ^ v_rt;
            `TINKER_OP_NOT:    return ~v_rs;
            `TINKER_OP_SHFTR:  return v_rs >> v_rt;
            `TINKER_OP_SHFTRI: return v_rs >> sext(lit);
            `TINKER_OP_SHFTL:  return v_rs << v_rt;
            `TINKER_OP_SHFTLI: return v_rs << sext(lit);
            `TINKER_OP_MOV:    return v_rs;
            default:           return sext(lit);          // movl
        endcase
    endfunction

    function tinker_pkg::lit_t rand_lit();
        return tinker_pkg::lit_t'($random(seed));
    endfunction

    task automatic alu(tinker_pkg::opcode_t op, tinker_pkg::reg_idx_t rd,
        tinker_pkg::reg_idx_t rs, tinker_pkg::reg_idx_t rt, tinker_pkg::lit_t lit);
        prog.push_back(encode(op, rd, rs, rt, lit));
        m[rd] = model_result(op, m[rs], m[rt], m[rd], lit);
    endtask

    // store rs at r0 + next slot, and expect it
    task automatic store(tinker_pkg::reg_idx_t rs);
        tinker_pkg::lit_t lit;
        lit = tinker_pkg::lit_t'(slot * 8);
        slot++;
        prog.push_back(encode(`TINKER_OP_STORE, 5'd0, rs, 5'd0, lit));
        exp_addr.push_back(tinker_pkg::daddr_t'(m[0] + sext(lit)));
        exp_data.push_back(m[rs]);
        exp_total++;
    endtask

    task automatic poison3();
        repeat (3) prog.push_back(encode(`TINKER_OP_STORE, 5'd0, 5'd0, 5'd0, 12'hFF8));
    endtask

    // rd = byte address four words past the branch that follows
    task automatic load_target(tinker_pkg::reg_idx_t rd);
        alu(`TINKER_OP_MOV, rd, 5'd20, 5'd0, 12'd0);
        alu(`TINKER_OP_ADDI, rd, 5'd0, 5'd0, tinker_pkg::lit_t'(4 * (prog.size() + 5)));
    endtask

    // ========================================
    // programs
    // ========================================
    task automatic build_arith();
        alu(`TINKER_OP_MOVL, 5'd1, 5'd0, 5'd0, rand_lit());
        alu(`TINKER_OP_MOVL, 5'd2, 5'd0, 5'd0, rand_lit());
        for (int i = 0; i < 6; i++) begin
            alu(`TINKER_OP_ADDI, 5'd1, 5'd0, 5'd0, rand_lit());
            store(5'd1);                                   // distance 1
            alu(`TINKER_OP_SUBI, 5'd2, 5'd0, 5'd0, rand_lit());
            alu(`TINKER_OP_ADD, 5'd3, 5'd1, 5'd2, 12'd0);
            store(5'd2);                                   // distance 2
            store(5'd3);
        end
    endtask

    task automatic build_logic();
        alu(`TINKER_OP_AND, 5'd4, 5'd1, 5'd2, 12'd0);
        alu(`TINKER_OP_OR, 5'd5, 5'd1, 5'd3, 12'd0);
        alu(`TINKER_OP_XOR, 5'd6, 5'd4, 5'd5, 12'd0);
        alu(`TINKER_OP_NOT, 5'd7, 5'd4, 5'd0, 12'd0);     // distance 3 from and
        for (int r = 4; r <= 7; r++) store(tinker_pkg::reg_idx_t'(r));
        alu(`TINKER_OP_MOVL, 5'd8, 5'd0, 5'd0, 12'd5);
        alu(`TINKER_OP_SHFTR, 5'd9, 5'd1, 5'd8, 12'd0);
        alu(`TINKER_OP_SHFTRI, 5'd10, 5'd2, 5'd0, 12'd7);
        alu(`TINKER_OP_SHFTL, 5'd11, 5'd9, 5'd8, 12'd0);
        alu(`TINKER_OP_SHFTLI, 5'd12, 5'd10, 5'd0, 12'd3);
        alu(`TINKER_OP_SUB, 5'd13, 5'd11, 5'd12, 12'd0);
        alu(`TINKER_OP_MOV, 5'd14, 5'd13, 5'd0, 12'd0);
        for (int r = 9; r <= 14; r++) store(tinker_pkg::reg_idx_t'(r));
    endtask

    task automatic build_control();
        alu(`TINKER_OP_MOVL, 5'd20, 5'd0, 5'd0, 12'd1);
        alu(`TINKER_OP_SHFTLI, 5'd20, 5'd20, 5'd0, 12'd13);   // r20 = start pc
        load_target(5'd21);
        prog.push_back(encode(`TINKER_OP_BR, 5'd21, 5'd0, 5'd0, 12'd0));
        poison3();
        store(5'd21);
        alu(`TINKER_OP_MOVL, 5'd22, 5'd0, 5'd0, 12'd16);
        prog.push_back(encode(`TINKER_OP_BRR, 5'd22, 5'd0, 5'd0, 12'd0));
        poison3();
        store(5'd22);
        prog.push_back(encode(`TINKER_OP_BRRL, 5'd0, 5'd0, 5'd0, 12'd16));
        poison3();
        store(5'd20);
        // brnz taken, then not taken on r0
        alu(`TINKER_OP_MOVL, 5'd24, 5'd0, 5'd0, 12'd1);
        load_target(5'd23);
        prog.push_back(encode(`TINKER_OP_BRNZ, 5'd23, 5'd24, 5'd0, 12'd0));
        poison3();
        store(5'd24);
        load_target(5'd23);
        prog.push_back(encode(`TINKER_OP_BRNZ, 5'd23, 5'd0, 5'd0, 12'd0));
        store(5'd23);
        // signed brgt, -5 > -9 taken and -9 > -5 not
        alu(`TINKER_OP_MOVL, 5'd25, 5'd0, 5'd0, 12'hFFB);
        alu(`TINKER_OP_MOVL, 5'd26, 5'd0, 5'd0, 12'hFF7);
        load_target(5'd27);
        prog.push_back(encode(`TINKER_OP_BRGT, 5'd27, 5'd25, 5'd26, 12'd0));
        poison3();
        store(5'd25);
        load_target(5'd27);
        prog.push_back(encode(`TINKER_OP_BRGT, 5'd27, 5'd26, 5'd25, 12'd0));
        store(5'd26);
    endtask

    task automatic end_program();
        prog.push_back(encode(`TINKER_OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0));
        poison3();   // stores behind halt must never issue
        prog.push_back(encode(`TINKER_OP_STORE, 5'd0, 5'd0, 5'd0, 12'hFF8));
    endtask

    // ========================================
    // drive and wait
    // ========================================
    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 32; i++) m[i] = '0;
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        slot      = 0;
        rx_count  = 0;
        exp_total = 0;
    endtask

    task automatic wait_for_hlt();
        int cyc;
        cyc = 0;
        while (!hlt && cyc < HLT_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!hlt) begin
            $display("timeout in %s: hlt did not rise within %0d cycles", test_name, cyc);
            err_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_program(string name);
        test_name = name;
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = tinker_pkg::imem_idx_t'(i);
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
        repeat (4) @(negedge clk);   // idle watch before start
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_for_hlt();
        repeat (10) @(negedge clk);
        if (rx_count != exp_total) begin
            $display("CHECK FAILED %s: store count expected %0d actual %0d",
                     test_name, exp_total, rx_count);
            err_count++;
        end
    endtask

    // store scoreboard
    always @(negedge clk) begin
        if (st_valid) begin
            rx_count++;
            if (exp_addr.size() == 0) begin
                $display("%s: store to %h with no store left to expect", test_name, st_addr);
                err_count++;
            end else begin
                if (st_addr !== exp_addr[0] || st_data !== exp_data[0]) begin
                    $display("CHECK FAILED %s: store %0d expected %h/%h actual %h/%h",
                             test_name, rx_count, exp_addr[0], exp_data[0], st_addr, st_data);
                    err_count++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        seed         = 32'h8ff3_8070;
        reset        = 1'b1;
        start        = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        err_count    = 0;
        assert_fails = 0;
        aborted      = 1'b0;
        test_name    = "reset";
        apply_reset();
        build_arith();
        build_logic();
        build_control();
        end_program();
        run_program("arith_logic_control");
        if (!aborted) begin
            apply_reset();
            if (hlt !== 1'b0) begin
                $display("CHECK FAILED restart: hlt expected 0 actual %b", hlt);
                err_count++;
            end
            build_arith();
            end_program();
            run_program("restart_arith");
        end
        $display("errors: %0d check, %0d assertion", err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
src/tinker_pkg.sv
src/fetch_unit.sv
src/register_file.sv
src/decode_stage.sv
src/execute_unit.sv
src/tinker_core.sv
verif/tb_clock.sv
verif/tinker_assertions.sv
verif/tinker_tb.sv

// File: run.sh
#!/bin/sh
# build and run the tinker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tinker_tb -f tb.f -o tinker_sim

./obj_dir/tinker_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
exit 1
